// File: hdl/gpu_defs.svh
// Shared width and size macros for the compute core RTL; include wherever these sizes are needed
`ifndef GPU_DEFS_SVH
`define GPU_DEFS_SVH

// Data path word, also the width of both host words
`define GPU_WORD_WIDTH 32

// Address field carried in a host command
`define GPU_HOST_ADDR_WIDTH 14

// Address bits each RAM decodes, 256 words
`define GPU_MEM_ADDR_BITS 8

// Integer register file depth
`define GPU_NUM_REGS 8

`endif

// File: hdl/host_link_pkg.sv
// Types for the host command link, the external RAM access bundle and core status; import where used
`include "gpu_defs.svh"

package host_link_pkg;

    // Host command codes, bits 30:27 of a command word
    typedef enum logic [3:0] {
        NOP          = 4'd0,
        RUN_SET      = 4'd1,
        RUN_CLEAR    = 4'd2,
        CORE_RESET   = 4'd3,
        WRITE_INST   = 4'd4,
        WRITE_DATA   = 4'd5,
        READ_INST    = 4'd6,
        READ_DATA    = 4'd7,
        READ_REG     = 4'd8,
        READ_SPECIAL = 4'd9
    } host_opcode_e;

    // Command word as the host lays it out
    typedef struct packed {
        logic                              toggle;
        host_opcode_e                      opcode;
        logic [`GPU_HOST_ADDR_WIDTH-1:0]   address;
        logic                              half_high;
        logic [11:0]                       reserved;
    } host_command_t;

    // Readback source for the reply half
    typedef enum logic [1:0] {
        INST,
        DATA,
        REG,
        SPECIAL
    } read_source_e;

    // Host side RAM write port into the core
    typedef struct packed {
        logic                              write_inst_en;
        logic                              write_data_en;
        logic [`GPU_HOST_ADDR_WIDTH-1:0]   address;
        logic [`GPU_WORD_WIDTH-1:0]        data;
    } ext_access_t;

    typedef struct packed {
        logic        halted;
        logic        exception;
        logic [23:0] exception_data;
    } core_status_t;

    // All four readback words, selected later by the reply builder
    typedef struct packed {
        logic [`GPU_WORD_WIDTH-1:0] inst_word;
        logic [`GPU_WORD_WIDTH-1:0] data_word;
        logic [`GPU_WORD_WIDTH-1:0] reg_word;
        logic [`GPU_WORD_WIDTH-1:0] special_word;
    } core_readback_t;

endpackage

// File: hdl/gpu_isa_pkg.sv
// Instruction format and opcodes of the compute core; import in the core and anything decoding programs
`include "gpu_defs.svh"

package gpu_isa_pkg;

    localparam int IMM_WIDTH = 22;

    // Core opcodes, every other code traps
    typedef enum logic [3:0] {
        ADDI  = 4'd1,
        ADD   = 4'd2,
        LOAD  = 4'd3,
        STORE = 4'd4,
        BNEZ  = 4'd5,
        HALT  = 4'd6
    } gpu_op_e;

    // 4 + 3 + 3 + 22 bits
    typedef struct packed {
        gpu_op_e                opcode;
        logic [2:0]             rd;
        logic [2:0]             rs;
        logic [IMM_WIDTH-1:0]   imm;
    } instruction_t;

    // Sign extend the immediate to a full word
    function automatic logic [`GPU_WORD_WIDTH-1:0] imm_ext(input instruction_t inst);
        return {{(`GPU_WORD_WIDTH - IMM_WIDTH){inst.imm[IMM_WIDTH-1]}}, inst.imm};
    endfunction

endpackage

// File: hdl/host_command_decoder.sv
// Input side: turns toggled host words into RAM writes, run control, core reset and read selects
`include "gpu_defs.svh"

module host_command_decoder (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [`GPU_WORD_WIDTH-1:0]        h2f_value,
    output host_link_pkg::ext_access_t        access,
    output logic                              run,
    output logic                              core_reset,
    output host_link_pkg::read_source_e       read_source,
    output logic [`GPU_HOST_ADDR_WIDTH-1:0]   read_address,
    output logic                              read_high,
    output logic                              reply_strobe,
    output logic                              reply_toggle
);
    import host_link_pkg::*;

    host_command_t                      word_q;
    logic                               last_toggle;
    logic                               new_word;
    logic                               is_command;
    // 0 command, 1 low data half, 2 high data half
    logic [1:0]                         seq;
    logic                               write_to_inst;
    logic [`GPU_HOST_ADDR_WIDTH-1:0]    write_address;
    logic [15:0]                        data_low;

    // ============================================================
    // Host word capture and toggle detect
    // ============================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            word_q      <= '0;
            last_toggle <= 1'b0;
        end else begin
            word_q      <= h2f_value;
            last_toggle <= word_q.toggle;
        end
    end

    // High for exactly one cycle per host word
    assign new_word   = word_q.toggle != last_toggle;
    assign is_command = new_word && (seq == 2'd0);

    assign core_reset = is_command && (word_q.opcode == CORE_RESET);

    // Write strobe fires on the third word of a write
    always_comb begin
        access         = '0;
        access.address = write_address;
        access.data    = {word_q[15:0], data_low};
        if (new_word && seq == 2'd2) begin
            access.write_inst_en = write_to_inst;
            access.write_data_en = !write_to_inst;
        end
    end

    // ============================================================
    // Sequence, run level, read select, acknowledge
    // ============================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            seq          <= 2'd0;
            run          <= 1'b0;
            read_source  <= INST;
            read_address <= '0;
            read_high    <= 1'b0;
            reply_strobe <= 1'b0;
            reply_toggle <= 1'b0;
        end else begin
            // Ack one cycle after detection
            reply_strobe <= new_word;
            if (new_word) begin
                reply_toggle <= word_q.toggle;
                case (seq)
                    2'd0: begin
                        case (word_q.opcode)
                            RUN_SET:                run <= 1'b1;
                            RUN_CLEAR:              run <= 1'b0;
                            WRITE_INST, WRITE_DATA: seq <= 2'd1;
                            READ_INST:              read_source <= INST;
                            READ_DATA:              read_source <= DATA;
                            READ_REG:               read_source <= REG;
                            READ_SPECIAL:           read_source <= SPECIAL;
                            default:                ;
                        endcase
                        if (word_q.opcode inside {READ_INST, READ_DATA, READ_REG, READ_SPECIAL}) begin
                            read_address <= word_q.address;
                            read_high    <= word_q.half_high;
                        end
                    end
                    2'd1:    seq <= 2'd2;
                    default: seq <= 2'd0;
                endcase
            end
        end
    end

    // Write payload, held until the strobe
    always_ff @(posedge clock) begin
        if (is_command) begin
            write_to_inst <= word_q.opcode == WRITE_INST;
            write_address <= word_q.address;
        end
        if (new_word && seq == 2'd1) begin
            data_low <= word_q[15:0];
        end
    end

    // Host waits for the ack, so detected words lie at least three cycles apart
    a_host_paced: assert property (@(posedge clock) disable iff (reset)
        new_word |=> !new_word [*2])
        else $error("host word arrived before its acknowledge");

endmodule

// File: hdl/gpu_core.sv
// Processing part: instruction and data RAM, eight registers, one instruction per clock while running
`include "gpu_defs.svh"

module gpu_core (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              core_reset,
    input  logic                              run,
    input  host_link_pkg::ext_access_t        access,
    input  logic [`GPU_HOST_ADDR_WIDTH-1:0]   read_address,
    output host_link_pkg::core_status_t       status,
    output host_link_pkg::core_readback_t     readback
);
    import host_link_pkg::*;
    import gpu_isa_pkg::*;

    localparam int MEM_DEPTH = 1 << `GPU_MEM_ADDR_BITS;
    localparam int REG_BITS  = $clog2(`GPU_NUM_REGS);

    logic [`GPU_WORD_WIDTH-1:0]     inst_ram [MEM_DEPTH];
    logic [`GPU_WORD_WIDTH-1:0]     data_ram [MEM_DEPTH];
    logic [`GPU_WORD_WIDTH-1:0]     regs [`GPU_NUM_REGS];

    logic [`GPU_MEM_ADDR_BITS-1:0]  pc;
    logic [`GPU_MEM_ADDR_BITS-1:0]  pc_next;
    logic [`GPU_MEM_ADDR_BITS-1:0]  mem_addr;
    logic [`GPU_MEM_ADDR_BITS-1:0]  host_mem_addr;
    logic                           halted;
    logic                           exception;
    logic [23:0]                    exception_data;

    instruction_t                   instr;
    logic [`GPU_WORD_WIDTH-1:0]     imm;
    logic [`GPU_WORD_WIDTH-1:0]     rs_val;
    logic [`GPU_WORD_WIDTH-1:0]     rd_val;
    logic [`GPU_WORD_WIDTH-1:0]     wb_value;
    logic                           wb_en;
    logic                           legal;
    logic                           step;

    // ============================================================
    // Fetch and decode
    // ============================================================
    assign instr  = inst_ram[pc];
    assign imm    = imm_ext(instr);
    // r0 reads as zero
    assign rs_val = (instr.rs == '0) ? '0 : regs[instr.rs];
    assign rd_val = (instr.rd == '0) ? '0 : regs[instr.rd];

    // Data RAM address wraps at 256
    assign mem_addr      = rs_val[`GPU_MEM_ADDR_BITS-1:0] + imm[`GPU_MEM_ADDR_BITS-1:0];
    assign host_mem_addr = access.address[`GPU_MEM_ADDR_BITS-1:0];

    assign legal = instr.opcode inside {ADDI, ADD, LOAD, STORE, BNEZ, HALT};
    assign step  = run && !halted && !exception && !core_reset;

    always_comb begin
        pc_next = pc + 1'b1;
        if (instr.opcode == BNEZ && rs_val != '0) begin
            pc_next = pc + imm[`GPU_MEM_ADDR_BITS-1:0];
        end
    end

    // Result select, ADD is rd = rd + rs
    always_comb begin
        wb_en    = 1'b0;
        wb_value = '0;
        case (instr.opcode)
            ADDI: begin
                wb_en    = 1'b1;
                wb_value = rs_val + imm;
            end
            ADD: begin
                wb_en    = 1'b1;
                wb_value = rd_val + rs_val;
            end
            LOAD: begin
                wb_en    = 1'b1;
                wb_value = data_ram[mem_addr];
            end
            default: ;
        endcase
    end

    // ============================================================
    // Execute state
    // ============================================================
    always_ff @(posedge clock) begin
        if (reset || core_reset) begin
            pc             <= '0;
            halted         <= 1'b0;
            exception      <= 1'b0;
            exception_data <= '0;
            for (int i = 0; i < `GPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (step) begin
            if (!legal) begin
                // pc in 23:16, opcode in 3:0
                exception      <= 1'b1;
                exception_data <= {8'(pc), 12'd0, 4'(instr.opcode)};
            end else if (instr.opcode == HALT) begin
                halted <= 1'b1;
            end else begin
                pc <= pc_next;
            end
            if (legal && wb_en && instr.rd != '0) begin
                regs[instr.rd] <= wb_value;
            end
        end
    end

    // Instruction RAM, host write only
    always_ff @(posedge clock) begin
        if (access.write_inst_en) begin
            inst_ram[host_mem_addr] <= access.data;
        end
    end

    // Data RAM, single write port shared by host and STORE
    always_ff @(posedge clock) begin
        if (access.write_data_en) begin
            data_ram[host_mem_addr] <= access.data;
        end else if (step && instr.opcode == STORE) begin
            data_ram[mem_addr] <= rd_val;
        end
    end

    // ============================================================
    // Status and host readback
    // ============================================================
    assign status.halted         = halted;
    assign status.exception      = exception;
    assign status.exception_data = exception_data;

    always_comb begin
        readback.inst_word = inst_ram[read_address[`GPU_MEM_ADDR_BITS-1:0]];
        readback.data_word = data_ram[read_address[`GPU_MEM_ADDR_BITS-1:0]];
        readback.reg_word  = (read_address[REG_BITS-1:0] == '0) ? '0
                                                               : regs[read_address[REG_BITS-1:0]];
        readback.special_word = '0;
        case (read_address)
            'd0: readback.special_word[`GPU_MEM_ADDR_BITS-1:0] = pc;
            'd1: readback.special_word[1:0] = {exception, halted};
            'd2: readback.special_word[23:0] = exception_data;
            default: ;
        endcase
    end

    // Stopped core holds its pc until a core reset
    a_pc_frozen: assert property (@(posedge clock) disable iff (reset)
        (halted || exception) && !core_reset |=> $stable(pc))
        else $error("pc moved while stopped");

endmodule

// File: hdl/host_reply_builder.sv
// Output side: picks the readback half and forms the acknowledge and status word for the host
`include "gpu_defs.svh"

module host_reply_builder (
    input  logic                              clock,
    input  logic                              reset,
    input  host_link_pkg::read_source_e       read_source,
    input  logic                              read_high,
    input  host_link_pkg::core_readback_t     readback,
    input  host_link_pkg::core_status_t       status,
    input  logic                              run,
    input  logic                              reply_strobe,
    input  logic                              reply_toggle,
    output logic [`GPU_WORD_WIDTH-1:0]        f2h_value
);
    import host_link_pkg::*;

    localparam int HALF = `GPU_WORD_WIDTH / 2;

    logic [`GPU_WORD_WIDTH-1:0] selected;
    logic [HALF-1:0]            half;
    logic [HALF-1:0]            reply_half;
    logic                       ack_toggle;

    // Source mux
    always_comb begin
        case (read_source)
            INST:    selected = readback.inst_word;
            DATA:    selected = readback.data_word;
            REG:     selected = readback.reg_word;
            default: selected = readback.special_word;
        endcase
    end

    assign half = read_high ? selected[`GPU_WORD_WIDTH-1:HALF] : selected[HALF-1:0];

    // Data and ack move together
    always_ff @(posedge clock) begin
        if (reset) begin
            ack_toggle <= 1'b0;
            reply_half <= '0;
        end else if (reply_strobe) begin
            ack_toggle <= reply_toggle;
            reply_half <= half;
        end
    end

    // Status bits live, not latched with the ack
    assign f2h_value = {ack_toggle, status.halted, status.exception, run, 12'd0, reply_half};

    // Every reply strobe carries a new host toggle
    a_ack_on_strobe: assert property (@(posedge clock) disable iff (reset)
        reply_strobe |=> !$stable(ack_toggle))
        else $error("reply strobe without a new acknowledge toggle");

endmodule

// File: hdl/gpu_system_top.sv
// Top level of the compute subsystem: host word in, reply word out; decoder, core and reply builder
`include "gpu_defs.svh"

module gpu_system_top (
    input  logic                        clock,
    input  logic                        reset,
    input  logic [`GPU_WORD_WIDTH-1:0]  h2f_value,
    output logic [`GPU_WORD_WIDTH-1:0]  f2h_value
);
    import host_link_pkg::*;

    ext_access_t                        access;
    logic                               run;
    logic                               core_reset;
    read_source_e                       read_source;
    logic [`GPU_HOST_ADDR_WIDTH-1:0]    read_address;
    logic                               read_high;
    logic                               reply_strobe;
    logic                               reply_toggle;
    core_status_t                       status;
    core_readback_t                     readback;

    // ============================================================
    // Input side, core, output side
    // ============================================================
    host_command_decoder u_decoder (
        .clock        (clock),
        .reset        (reset),
        .h2f_value    (h2f_value),
        .access       (access),
        .run          (run),
        .core_reset   (core_reset),
        .read_source  (read_source),
        .read_address (read_address),
        .read_high    (read_high),
        .reply_strobe (reply_strobe),
        .reply_toggle (reply_toggle)
    );

    gpu_core u_core (
        .clock        (clock),
        .reset        (reset),
        .core_reset   (core_reset),
        .run          (run),
        .access       (access),
        .read_address (read_address),
        .status       (status),
        .readback     (readback)
    );

    host_reply_builder u_reply (
        .clock        (clock),
        .reset        (reset),
        .read_source  (read_source),
        .read_high    (read_high),
        .readback     (readback),
        .status       (status),
        .run          (run),
        .reply_strobe (reply_strobe),
        .reply_toggle (reply_toggle),
        .f2h_value    (f2h_value)
    );

endmodule

// File: verification/tb_clock_gen.sv
// Testbench clock of period 4 and a synchronous reset held high for the first 2 cycles
module tb_clock_gen (
    output logic clock,
    output logic reset
);
    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Release on a rising edge so the DUT sees a clean deassert
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clock);
        reset <= 1'b0;
    end
endmodule

// File: verification/gpu_system_tb.sv
// Testbench of the compute subsystem: host word stimulus, reference model and reply assertions
`include "gpu_defs.svh"

module gpu_system_tb;
    import host_link_pkg::*;
    import gpu_isa_pkg::*;

    localparam int          MEM_DEPTH       = 1 << `GPU_MEM_ADDR_BITS;
    localparam int          RANDOM_WRITES   = 20;
    localparam int          HALTED_BIT      = 30;
    localparam int          EXCEPTION_BIT   = 29;
    localparam logic [7:0]  TRAP_PC         = 8'd2;
    localparam logic [3:0]  TRAP_OP         = 4'hF;
    // Host words over all tests, rounded up
    localparam int          HOST_WORDS      = 420;
    localparam int          PROGRAM_CYCLES  = 100;
    localparam int          WATCHDOG_CYCLES = HOST_WORDS * 20 + PROGRAM_CYCLES + 500;

    logic        clock;
    logic        reset;
    logic [31:0] h2f_value;
    logic [31:0] f2h_value;
    logic        host_toggle;
    logic [31:0] rng_state;
    int          errors;
    int          checks;
    // Masked reply compare, armed for one cycle
    logic        check_en;
    logic [31:0] check_mask;
    logic [31:0] check_value;

    // Reference memories
    logic [31:0] model_inst [MEM_DEPTH];
    logic [31:0] model_data [MEM_DEPTH];
    logic [7:0]  data_addr [RANDOM_WRITES];
    logic [7:0]  inst_addr [RANDOM_WRITES];

    tb_clock_gen clock_gen (.clock(clock), .reset(reset));

    gpu_system_top DUT (
        .clock     (clock),
        .reset     (reset),
        .h2f_value (h2f_value),
        .f2h_value (f2h_value)
    );

    // ============================================================
    // Checkers
    // ============================================================
    a_reply_matches: assert property (@(posedge clock) disable iff (reset)
        check_en |-> (f2h_value & check_mask) == check_value)
        else begin
            errors++;
            $display("** Error @ %0t: reply %h, expected %h under mask %h",
                     $time, $sampled(f2h_value), check_value, check_mask);
        end

    // Ack, status and run all zero out of reset
    a_reset_reply: assert property (@(posedge clock) $fell(reset) |-> f2h_value[31:28] == 4'd0)
        else begin
            errors++;
            $display("** Error @ %0t: reply %h after reset", $time, $sampled(f2h_value));
        end

    // Ack only moves to the toggle the host sent
    a_ack_follows_host: assert property (@(posedge clock) disable iff (reset)
        !$stable(f2h_value[31]) |-> f2h_value[31] == h2f_value[31])
        else begin
            errors++;
            $display("** Error @ %0t: ack toggle %b, host toggle %b",
                     $time, $sampled(f2h_value[31]), $sampled(h2f_value[31]));
        end

    // ============================================================
    // Helpers
    // ============================================================
    function automatic logic [31:0] xorshift32();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    // Host command body below the toggle bit
    function automatic logic [30:0] command(input host_opcode_e op, input logic [13:0] addr,
                                            input logic high);
        return {op, addr, high, 12'd0};
    endfunction

    function automatic logic [31:0] encode(input logic [3:0] op, input logic [2:0] rd,
                                           input logic [2:0] rs, input int imm);
        return {op, rd, rs, imm[21:0]};
    endfunction

    // One host word, returns once the ack toggle matches
    task automatic send_word(input logic [30:0] body);
        host_toggle = !host_toggle;
        @(posedge clock);
        h2f_value <= {host_toggle, body};
        do @(posedge clock); while (f2h_value[31] != host_toggle);
    endtask

    task automatic expect_reply(input logic [31:0] mask, input logic [31:0] value);
        @(posedge clock);
        check_mask  <= mask;
        check_value <= value;
        check_en    <= 1'b1;
        @(posedge clock);
        check_en    <= 1'b0;
        checks++;
    endtask

    // Three word write, model updated alongside
    task automatic write_word(input host_opcode_e op, input logic [13:0] addr,
                              input logic [31:0] data);
        send_word(command(op, addr, 1'b0));
        send_word({15'd0, data[15:0]});
        send_word({15'd0, data[31:16]});
        if (op == WRITE_INST)
            model_inst[addr[7:0]] = data;
        else
            model_data[addr[7:0]] = data;
    endtask

    task automatic read_word(input host_opcode_e op, input logic [13:0] addr,
                             input logic [31:0] expected);
        send_word(command(op, addr, 1'b0));
        expect_reply(32'h0000_FFFF, {16'd0, expected[15:0]});
        send_word(command(op, addr, 1'b1));
        expect_reply(32'h0000_FFFF, {16'd0, expected[31:16]});
    endtask

    task automatic wait_status(input int status_bit);
        do @(posedge clock); while (!f2h_value[status_bit]);
    endtask

    // ============================================================
    // Stimulus
    // ============================================================
    initial begin
        logic [31:0] r;
        int          n;
        int          expected_sum;
        logic [7:0]  store_addr;
        logic [15:0] held_pc;
        h2f_value   = '0;
        host_toggle = 1'b0;
        rng_state   = 32'h5558a53c;
        errors      = 0;
        checks      = 0;
        check_en    = 1'b0;
        check_mask  = '0;
        check_value = '0;
        @(negedge reset);
        expect_reply(32'hF000_0000, 32'h0);

        // Random RAM writes, then full readback
        for (int i = 0; i < RANDOM_WRITES; i++) begin
            r = xorshift32();
            data_addr[i] = r[7:0];
            inst_addr[i] = r[15:8];
            write_word(WRITE_DATA, data_addr[i], xorshift32());
            write_word(WRITE_INST, inst_addr[i], xorshift32());
        end
        for (int i = 0; i < RANDOM_WRITES; i++) begin
            read_word(READ_DATA, data_addr[i], model_data[data_addr[i]]);
            read_word(READ_INST, inst_addr[i], model_inst[inst_addr[i]]);
        end

        // Sum of 1 to N, r1 counts down, r2 accumulates
        r = xorshift32();
        n = 1 + r % 20;
        r = xorshift32();
        store_addr   = r[7:0];
        expected_sum = 0;
        for (int k = 1; k <= n; k++)
            expected_sum += k;
        write_word(WRITE_INST, 0, encode(ADDI, 1, 0, n));
        write_word(WRITE_INST, 1, encode(ADDI, 2, 0, 0));
        write_word(WRITE_INST, 2, encode(ADD, 2, 1, 0));
        write_word(WRITE_INST, 3, encode(ADDI, 1, 1, -1));
        write_word(WRITE_INST, 4, encode(BNEZ, 0, 1, -2));
        write_word(WRITE_INST, 5, encode(STORE, 2, 0, store_addr));
        write_word(WRITE_INST, 6, encode(HALT, 0, 0, 0));
        send_word(command(RUN_SET, 0, 1'b0));
        wait_status(HALTED_BIT);
        // Halted with run still set
        expect_reply(32'h7000_0000, 32'h5000_0000);
        model_data[store_addr] = expected_sum;
        read_word(READ_REG, 2, expected_sum);
        read_word(READ_DATA, store_addr, model_data[store_addr]);

        // Trap on an illegal opcode at TRAP_PC
        send_word(command(RUN_CLEAR, 0, 1'b0));
        send_word(command(CORE_RESET, 0, 1'b0));
        write_word(WRITE_INST, 0, encode(ADDI, 1, 0, 5));
        write_word(WRITE_INST, 1, encode(ADDI, 1, 1, 1));
        write_word(WRITE_INST, TRAP_PC, {TRAP_OP, 28'd0});
        send_word(command(RUN_SET, 0, 1'b0));
        wait_status(EXCEPTION_BIT);
        expect_reply(32'h7000_0000, 32'h3000_0000);
        read_word(READ_SPECIAL, 2, {8'd0, TRAP_PC, 12'd0, TRAP_OP});
        repeat (3) read_word(READ_SPECIAL, 0, 32'(TRAP_PC));
        read_word(READ_REG, 1, 6);

        // Core reset clears state, RAMs keep their contents
        send_word(command(RUN_CLEAR, 0, 1'b0));
        send_word(command(CORE_RESET, 0, 1'b0));
        expect_reply(32'h7000_0000, 32'h0);
        read_word(READ_SPECIAL, 0, 0);
        read_word(READ_SPECIAL, 1, 0);
        read_word(READ_REG, 2, 0);
        for (int i = 0; i < RANDOM_WRITES; i++) begin
            read_word(READ_DATA, data_addr[i], model_data[data_addr[i]]);
            read_word(READ_INST, inst_addr[i], model_inst[inst_addr[i]]);
        end

        // Endless loop over pc 1 and 2, stopped by RUN_CLEAR
        write_word(WRITE_INST, 0, encode(ADDI, 1, 0, 1));
        write_word(WRITE_INST, 1, encode(ADDI, 2, 2, 1));
        write_word(WRITE_INST, 2, encode(BNEZ, 0, 1, -1));
        send_word(command(RUN_SET, 0, 1'b0));
        send_word(command(RUN_CLEAR, 0, 1'b0));
        send_word(command(READ_SPECIAL, 0, 1'b0));
        held_pc = f2h_value[15:0];
        a_pc_in_loop: assert (held_pc inside {16'd1, 16'd2})
            else begin
                errors++;
                $display("** Error @ %0t: pc %0d outside the loop body", $time, held_pc);
            end
        repeat (4) begin
            send_word(command(READ_SPECIAL, 0, 1'b0));
            expect_reply(32'h1000_FFFF, {16'd0, held_pc});
        end

        // Let the last assertion actions settle
        repeat (2) @(posedge clock);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end
endmodule

// File: src.f
+incdir+hdl
hdl/host_link_pkg.sv
hdl/gpu_isa_pkg.sv
hdl/host_command_decoder.sv
hdl/gpu_core.sv
hdl/host_reply_builder.sv
hdl/gpu_system_top.sv
verification/tb_clock_gen.sv
verification/gpu_system_tb.sv
